// ==== verilog.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_repl.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_top.sv
test/icache_mem_model.sv
test/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - logic

sources:
  # cache RTL, package first
  - files:
      - logic/icache_pkg.sv
      - logic/icache_ctrl.sv
      - logic/icache_repl.sv
      - logic/icache_tag_array.sv
      - logic/icache_data_array.sv
      - logic/icache_top.sv
  # simulation only
  - target: test
    files:
      - test/icache_mem_model.sv
      - test/tb_icache.sv

// ==== test/tb_icache.sv ====
// testbench for icache_top, runs directed and random fetches and checks them with assertions
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module tb_icache;

  import icache_pkg::*;

  localparam int unsigned ClkPeriod       = 100;
  localparam int unsigned ResetCycles     = 4;
  localparam int unsigned MemDelay        = 3;
  localparam int unsigned RandomFetches   = 40;
  localparam int unsigned DirectedFetches = 17;
  // a fetch may sit behind a full flush, then wait out a refill
  localparam int unsigned ReadyTimeout    = `ICACHE_SETS + 8;
  localparam int unsigned RspTimeout      = MemDelay + 8;
  localparam int unsigned FetchWorst      = ReadyTimeout + RspTimeout + 2;
  localparam int unsigned WatchdogCycles  =
      ResetCycles + (DirectedFetches + RandomFetches) * FetchWorst + 64;

  logic       clk_i;
  logic       rst_ni;
  logic       en_i;
  logic       flush_i;
  logic       miss_o;
  fetch_req_t fetch_req_i;
  logic       fetch_valid_i;
  logic       fetch_ready_o;
  fetch_rsp_t fetch_rsp_o;
  logic       fetch_rsp_valid_o;
  logic       mem_req_o;
  mem_req_t   mem_req_data_o;
  logic       mem_rtrn_valid_i;
  mem_rtrn_t  mem_rtrn_i;

  // expectations set by the stimulus, sampled by the assertions
  logic        expect_hit;
  logic        expect_miss;
  logic        check_way;
  way_idx_t    exp_way;
  addr_t       pend_addr;
  addr_t       exp_paddr;
  word_t       exp_word;
  logic        accept;
  // bookkeeping
  string       test_name;
  int unsigned err_cnt;
  int unsigned test_err_start;
  int unsigned test_cnt;
  int unsigned fetch_cnt;
  int unsigned rsp_cnt;
  logic [31:0] lcg_state;

  icache_top DUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .en_i              (en_i),
    .flush_i           (flush_i),
    .miss_o            (miss_o),
    .fetch_req_i       (fetch_req_i),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .mem_req_o         (mem_req_o),
    .mem_req_data_o    (mem_req_data_o),
    .mem_rtrn_valid_i  (mem_rtrn_valid_i),
    .mem_rtrn_i        (mem_rtrn_i)
  );

  icache_mem_model #(
    .Delay (MemDelay)
  ) i_mem_model (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (mem_req_o),
    .req_data_i   (mem_req_data_o),
    .rtrn_valid_o (mem_rtrn_valid_i),
    .rtrn_o       (mem_rtrn_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference values
  //////////////////////////////

  // word at an address, low two bits dropped
  function automatic word_t word_at(input addr_t addr);
    addr_t aligned;
    aligned = {addr[`ICACHE_ADDR_WIDTH-1:2], 2'b00};
    return {aligned[15:0], ~aligned[15:0]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  assign accept   = fetch_valid_i & fetch_ready_o;
  assign exp_word = word_at(pend_addr);
  // line aligned when cached, word aligned when bypassed
  assign exp_paddr = en_i ?
      {pend_addr[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH], {`ICACHE_OFFSET_WIDTH{1'b0}}} :
      {pend_addr[`ICACHE_ADDR_WIDTH-1:2], 2'b00};

  // address of the request being answered, and responses seen so far
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_addr <= '0;
      rsp_cnt   <= 0;
    end else begin
      if (accept) begin
        pend_addr <= fetch_req_i.addr;
      end
      if (fetch_rsp_valid_o) begin
        rsp_cnt <= rsp_cnt + 1;
      end
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  check_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_rsp_valid_o |-> (fetch_rsp_o.data == exp_word))
    else begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: response data expected %h, actual %h",
               test_name, $sampled(exp_word), $sampled(fetch_rsp_o.data));
    end

  // a hit answers in the next cycle with the port ready for the next fetch and never reaches memory
  check_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (accept && expect_hit) |=> (fetch_rsp_valid_o && fetch_ready_o && !mem_req_o))
    else begin
      err_cnt = err_cnt + 1;
      $display("in %s a fetch that should hit was not answered one cycle after accept %s",
               test_name, "with the cache ready again");
    end

  check_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (accept && expect_miss) |=> mem_req_o)
    else begin
      err_cnt = err_cnt + 1;
      $display("in %s a fetch that should miss sent no refill request", test_name);
    end

  check_paddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o |-> (mem_req_data_o.paddr == exp_paddr))
    else begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: refill address expected %h, actual %h",
               test_name, $sampled(exp_paddr), $sampled(mem_req_data_o.paddr));
    end

  check_nc: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_o |-> (mem_req_data_o.nc == !en_i))
    else begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: refill nc expected %b, actual %b",
               test_name, !$sampled(en_i), $sampled(mem_req_data_o.nc));
    end

  // counter strobe only for cacheable refills
  check_miss_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
      miss_o == (mem_req_o && en_i))
    else begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: miss strobe expected %b, actual %b",
               test_name, $sampled(mem_req_o && en_i), $sampled(miss_o));
    end

  check_victim: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_o && check_way) |-> (mem_req_data_o.way == exp_way))
    else begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: refill way expected %0d, actual %0d",
               test_name, $sampled(exp_way), $sampled(mem_req_data_o.way));
    end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // called just after a rising edge, returns on the accepting edge
  task automatic issue(input addr_t addr, input logic hit, input logic miss);
    int unsigned waited;
    waited = 0;
    fetch_req_i.addr <= addr;
    fetch_valid_i    <= 1'b1;
    expect_hit       <= hit;
    expect_miss      <= miss;
    fetch_cnt = fetch_cnt + 1;
    @(negedge clk_i);
    while (!fetch_ready_o && waited < ReadyTimeout) begin
      waited = waited + 1;
      @(negedge clk_i);
    end
    if (!fetch_ready_o) begin
      err_cnt = err_cnt + 1;
      $display("in %s the cache never became ready for address %h", test_name, addr);
    end
    @(posedge clk_i);
  endtask

  task automatic stop_fetch();
    fetch_valid_i <= 1'b0;
    expect_hit    <= 1'b0;
    expect_miss   <= 1'b0;
  endtask

  task automatic wait_responses(input int unsigned target);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    while (rsp_cnt < target && waited < RspTimeout) begin
      waited = waited + 1;
      @(negedge clk_i);
    end
    if (rsp_cnt < target) begin
      err_cnt = err_cnt + 1;
      $display("in %s a response did not arrive in time", test_name);
    end
    @(posedge clk_i);
  endtask

  task automatic fetch_one(input addr_t addr, input logic hit, input logic miss);
    issue(addr, hit, miss);
    stop_fetch();
    wait_responses(fetch_cnt);
  endtask

  // latched by the cache, carried out at its next idle cycle
  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
    test_cnt       = test_cnt + 1;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", test_name, err_cnt - test_err_start);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    en_i          = 1'b1;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
    expect_hit    = 1'b0;
    expect_miss   = 1'b0;
    check_way     = 1'b0;
    exp_way       = '0;
    test_name     = "reset";
    err_cnt       = 0;
    test_cnt      = 0;
    fetch_cnt     = 0;
    lcg_state     = 32'he299;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // cold cache, set 4 starts empty
    start_test("first_miss");
    check_way <= 1'b1;
    exp_way   <= way_idx_t'(0);
    fetch_one(32'h0000_1040, 1'b0, 1'b1);
    check_way <= 1'b0;
    end_test();

    start_test("hit_repeat");
    fetch_one(32'h0000_1044, 1'b1, 1'b0);
    // two hits in flight
    issue(32'h0000_1048, 1'b1, 1'b0);
    issue(32'h0000_104C, 1'b1, 1'b0);
    stop_fetch();
    wait_responses(fetch_cnt);
    end_test();

    // four tags into set 5 take ways 0 to 3
    start_test("way_fill");
    pulse_flush();
    check_way <= 1'b1;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      exp_way <= way_idx_t'(w);
      fetch_one(addr_t'((w + 1) << 16) | 32'h50, 1'b0, 1'b1);
    end
    check_way <= 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      fetch_one(addr_t'((w + 1) << 16) | 32'h5C, 1'b1, 1'b0);
    end
    end_test();

    start_test("flush_clear");
    pulse_flush();
    check_way <= 1'b1;
    exp_way   <= way_idx_t'(0);
    fetch_one(32'h0001_0054, 1'b0, 1'b1);
    check_way <= 1'b0;
    end_test();

    // bypass ignores the line still held in set 5
    start_test("bypass");
    en_i <= 1'b0;
    fetch_one(32'h0000_2124, 1'b0, 1'b1);
    fetch_one(32'h0000_2124, 1'b0, 1'b1);
    fetch_one(32'h0001_0054, 1'b0, 1'b1);
    fetch_one(32'h0000_2127, 1'b0, 1'b1);
    end_test();

    // 8 tags over 16 sets, so full sets fall back to the random way
    start_test("random");
    en_i <= 1'b1;
    for (int i = 0; i < RandomFetches; i++) begin
      lcg_state = lcg_next(lcg_state);
      fetch_one({21'b0, lcg_state[18:8]}, 1'b0, 1'b0);
    end
    end_test();

    // one response per accepted fetch
    if (rsp_cnt != fetch_cnt) begin
      err_cnt = err_cnt + 1;
      $display("Error in %s: response count expected %0d, actual %0d",
               test_name, fetch_cnt, rsp_cnt);
    end

    $display("%0d tests, %0d fetches, %0d responses, %0d errors",
             test_cnt, fetch_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/icache_mem_model.sv ====
// refill responder for the instruction cache testbench, answers each request with one full line
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_mem_model #(
  parameter int unsigned Delay = 3
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 req_i,
  input  wire icache_pkg::mem_req_t req_data_i,
  output logic                      rtrn_valid_o,
  output icache_pkg::mem_rtrn_t     rtrn_o
);

  import icache_pkg::*;

  localparam int unsigned WordsPerLine = `ICACHE_LINE_WIDTH / `ICACHE_WORD_WIDTH;
  localparam int unsigned WordBytes    = `ICACHE_WORD_WIDTH / 8;

  logic        busy_q;
  int unsigned cnt_q;
  addr_t       line_addr_q;

  // each word holds the low half of its own address, then that half inverted
  function automatic line_t build_line(input addr_t base);
    line_t line;
    addr_t word_addr;
    line = '0;
    for (int w = 0; w < WordsPerLine; w++) begin
      word_addr = base + addr_t'(w * WordBytes);
      line[w * `ICACHE_WORD_WIDTH +: `ICACHE_WORD_WIDTH] = {word_addr[15:0], ~word_addr[15:0]};
    end
    return line;
  endfunction

  // one request at a time, answered Delay cycles after its strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      cnt_q        <= 0;
      line_addr_q  <= '0;
      rtrn_valid_o <= 1'b0;
      rtrn_o       <= '0;
    end else begin
      rtrn_valid_o <= 1'b0;
      if (req_i) begin
        busy_q      <= 1'b1;
        cnt_q       <= Delay - 1;
        // bypass requests are word aligned, the line around them is returned
        line_addr_q <= {req_data_i.paddr[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                        {`ICACHE_OFFSET_WIDTH{1'b0}}};
      end else if (busy_q) begin
        if (cnt_q == 1) begin
          busy_q       <= 1'b0;
          rtrn_valid_o <= 1'b1;
          rtrn_o.data  <= build_line(line_addr_q);
        end else begin
          cnt_q <= cnt_q - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
// top level of the instruction cache, connects controller, arrays and replacement
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   en_i,
  input  wire logic                   flush_i,
  output logic                        miss_o,
  input  wire icache_pkg::fetch_req_t fetch_req_i,
  input  wire logic                   fetch_valid_i,
  output logic                        fetch_ready_o,
  output icache_pkg::fetch_rsp_t      fetch_rsp_o,
  output logic                        fetch_rsp_valid_o,
  output logic                        mem_req_o,
  output icache_pkg::mem_req_t        mem_req_data_o,
  input  wire logic                   mem_rtrn_valid_i,
  input  wire icache_pkg::mem_rtrn_t  mem_rtrn_i
);

  import icache_pkg::*;

  // array control from the controller
  index_t   index;
  tag_t     tag;
  offset_t  offset;
  logic     lookup;
  logic     fill;
  logic     flush_set;
  logic     use_array;

  // lookup results
  way_vec_t hit_vec;
  way_idx_t hit_way;
  way_vec_t valid_vec;
  way_idx_t victim_way;

  icache_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .en_i              (en_i),
    .flush_i           (flush_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_valid_i     (fetch_valid_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .hit_i             (|hit_vec),
    .victim_way_i      (victim_way),
    .mem_req_o         (mem_req_o),
    .mem_req_data_o    (mem_req_data_o),
    .mem_rtrn_valid_i  (mem_rtrn_valid_i),
    .miss_o            (miss_o),
    .index_o           (index),
    .tag_o             (tag),
    .offset_o          (offset),
    .lookup_o          (lookup),
    .fill_o            (fill),
    .flush_set_o       (flush_set),
    .use_array_o       (use_array)
  );

  icache_tag_array i_tag_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .index_i     (index),
    .tag_i       (tag),
    .lookup_i    (lookup),
    .fill_i      (fill),
    .flush_set_i (flush_set),
    .fill_way_i  (victim_way),
    .hit_o       (hit_vec),
    .hit_way_o   (hit_way),
    .valid_o     (valid_vec)
  );

  icache_repl i_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid_vec),
    .lookup_done_i (lookup),
    .fill_i        (fill),
    .victim_way_o  (victim_way)
  );

  icache_data_array i_data_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .index_i     (index),
    .lookup_i    (lookup),
    .fill_i      (fill),
    .fill_way_i  (victim_way),
    .hit_way_i   (hit_way),
    .offset_i    (offset),
    .use_array_i (use_array),
    .mem_rtrn_i  (mem_rtrn_i),
    .fetch_rsp_o (fetch_rsp_o)
  );

endmodule

`default_nettype wire

// ==== logic/icache_data_array.sv ====
// line storage of the instruction cache and fetch word select, one instance in icache_top
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_data_array (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire icache_pkg::index_t    index_i,
  input  wire logic                  lookup_i,
  input  wire logic                  fill_i,
  input  wire icache_pkg::way_idx_t  fill_way_i,
  input  wire icache_pkg::way_idx_t  hit_way_i,
  input  wire icache_pkg::offset_t   offset_i,
  input  wire logic                  use_array_i,
  input  wire icache_pkg::mem_rtrn_t mem_rtrn_i,
  output icache_pkg::fetch_rsp_t     fetch_rsp_o
);

  import icache_pkg::*;

  localparam int unsigned WordsPerLine = `ICACHE_LINE_WIDTH / `ICACHE_WORD_WIDTH;
  localparam int unsigned WordSelWidth = $clog2(WordsPerLine);

  line_t                   line_mem [`ICACHE_SETS][`ICACHE_WAYS];
  line_t                   line_rd_q [`ICACHE_WAYS];
  line_t                   line_sel;
  logic [WordSelWidth-1:0] word_sel;
  word_t                   rsp_word;

  // refill writes the whole line into the victim way
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      line_mem[index_i][fill_way_i] <= mem_rtrn_i.data;
    end
  end

  // all ways of the set are read, the hit picks one a cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        line_rd_q[w] <= '0;
      end
    end else if (lookup_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        line_rd_q[w] <= line_mem[index_i][w];
      end
    end
  end

  // word number inside the line
  assign word_sel = offset_i[`ICACHE_OFFSET_WIDTH-1 -: WordSelWidth];

  assign line_sel = use_array_i ? line_rd_q[hit_way_i] : mem_rtrn_i.data;
  assign rsp_word = line_sel[word_sel * `ICACHE_WORD_WIDTH +: `ICACHE_WORD_WIDTH];

  assign fetch_rsp_o.data = rsp_word;

endmodule

`default_nettype wire

// ==== logic/icache_tag_array.sv ====
// tag and valid storage of the instruction cache with hit compare, one instance in icache_top
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_tag_array (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire icache_pkg::index_t   index_i,
  input  wire icache_pkg::tag_t     tag_i,
  input  wire logic                 lookup_i,
  input  wire logic                 fill_i,
  input  wire logic                 flush_set_i,
  input  wire icache_pkg::way_idx_t fill_way_i,
  output icache_pkg::way_vec_t      hit_o,
  output icache_pkg::way_idx_t      hit_way_o,
  output icache_pkg::way_vec_t      valid_o
);

  import icache_pkg::*;

  // tag storage per set and way
  tag_t     tag_mem [`ICACHE_SETS][`ICACHE_WAYS];
  way_vec_t valid_q [`ICACHE_SETS];

  // lookup read registers
  tag_t     tag_rd_q [`ICACHE_WAYS];
  way_vec_t valid_rd_q;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_mem[index_i][fill_way_i] <= tag_i;
    end
  end

  // flush clears the whole set, fill marks one way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (flush_set_i) begin
      valid_q[index_i] <= '0;
    end else if (fill_i) begin
      valid_q[index_i][fill_way_i] <= 1'b1;
    end
  end

  // current set state for the replacement choice
  assign valid_o = valid_q[index_i];

  //////////////////////////////
  // lookup and compare
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        tag_rd_q[w] <= tag_mem[index_i][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_rd_q <= '0;
    end else if (lookup_i) begin
      valid_rd_q <= valid_q[index_i];
    end
  end

  // compare against the held request tag
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_o[w] = valid_rd_q[w] & (tag_rd_q[w] == tag_i);
    end
  end

  // lowest hitting way
  always_comb begin
    hit_way_o = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_o[w]) begin
        hit_way_o = way_idx_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_repl.sv ====
// replacement way choice for refills, lowest invalid way first and random once the set is full
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_repl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire icache_pkg::way_vec_t valid_i,
  input  wire logic                 lookup_done_i,
  input  wire logic                 fill_i,
  output icache_pkg::way_idx_t      victim_way_o
);

  import icache_pkg::*;

  // galois feedback for x^8 + x^6 + x^5 + x^4 + 1
  localparam logic [`ICACHE_LFSR_WIDTH-1:0] LfsrTaps = 8'hB8;

  logic [`ICACHE_LFSR_WIDTH-1:0] lfsr_d, lfsr_q;
  logic                          all_valid;
  way_idx_t                      inv_way;
  way_idx_t                      victim_d, victim_q;

  assign all_valid = &valid_i;

  // scan from the top so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  assign victim_d = all_valid ? lfsr_q[$bits(way_idx_t)-1:0] : inv_way;

  // shift right, fold taps in when a one drops out
  assign lfsr_d = {1'b0, lfsr_q[`ICACHE_LFSR_WIDTH-1:1]} ^
                  ({`ICACHE_LFSR_WIDTH{lfsr_q[0]}} & LfsrTaps);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= {{(`ICACHE_LFSR_WIDTH-1){1'b0}}, 1'b1};
      victim_q <= '0;
    end else begin
      // only full sets consume a random value
      if (fill_i && all_valid) begin
        lfsr_q <= lfsr_d;
      end
      if (lookup_done_i) begin
        victim_q <= victim_d;
      end
    end
  end

  assign victim_way_o = victim_q;

endmodule

`default_nettype wire

// ==== logic/icache_ctrl.sv ====
// instruction cache controller for flush, lookup and refill sequencing, used inside icache_top
`timescale 1ns/1ps
`default_nettype none
`include "icache_params.svh"

module icache_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   en_i,
  input  wire logic                   flush_i,
  input  wire icache_pkg::fetch_req_t fetch_req_i,
  input  wire logic                   fetch_valid_i,
  output logic                        fetch_ready_o,
  output logic                        fetch_rsp_valid_o,
  input  wire logic                   hit_i,
  input  wire icache_pkg::way_idx_t   victim_way_i,
  output logic                        mem_req_o,
  output icache_pkg::mem_req_t        mem_req_data_o,
  input  wire logic                   mem_rtrn_valid_i,
  output logic                        miss_o,
  output icache_pkg::index_t          index_o,
  output icache_pkg::tag_t            tag_o,
  output icache_pkg::offset_t         offset_o,
  output logic                        lookup_o,
  output logic                        fill_o,
  output logic                        flush_set_o,
  output logic                        use_array_o
);

  import icache_pkg::*;

  ctrl_state_e state_d, state_q;
  // enable only rises through a flush
  logic        cache_en_d, cache_en_q;
  logic        cache_en;
  // flush request waiting for idle
  logic        flush_d, flush_q;
  index_t      flush_cnt_d, flush_cnt_q;
  logic        flush_done;
  // outstanding refill bypasses the arrays
  logic        nc_d, nc_q;
  addr_t       addr_q;
  logic        hit;

  //////////////////////////////
  // request fields
  //////////////////////////////

  // a cleared en_i counts in the same cycle
  assign cache_en   = cache_en_q & en_i;
  assign hit        = hit_i & cache_en;
  assign flush_done = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));

  assign tag_o    = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign offset_o = addr_q[`ICACHE_OFFSET_WIDTH-1:0];

  // flush walks the sets, refill writes the held set, otherwise the incoming one
  assign index_o = (state_q == FLUSH) ? flush_cnt_q :
                   (state_q == MISS)  ? addr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH] :
                                        fetch_req_i.addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];

  assign lookup_o    = fetch_valid_i & fetch_ready_o;
  // array word in the compare cycle, refill word in the miss cycle
  assign use_array_o = (state_q == READ);

  // word aligned for bypass, line aligned for a cacheable miss
  assign mem_req_data_o.paddr = cache_en ?
      {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH], {`ICACHE_OFFSET_WIDTH{1'b0}}} :
      {addr_q[`ICACHE_ADDR_WIDTH-1:2], 2'b00};
  assign mem_req_data_o.way = victim_way_i;
  assign mem_req_data_o.nc  = ~cache_en;

  assign flush_cnt_d = (state_q != FLUSH) ? flush_cnt_q :
                       flush_done         ? '0          :
                                            flush_cnt_q + 1'b1;

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_comb begin
    state_d           = state_q;
    cache_en_d        = cache_en;
    flush_d           = flush_q | flush_i;
    nc_d              = nc_q;
    fetch_ready_o     = 1'b0;
    fetch_rsp_valid_o = 1'b0;
    mem_req_o         = 1'b0;
    miss_o            = 1'b0;
    fill_o            = 1'b0;
    flush_set_o       = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_set_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        // pending flush or fresh enable goes first
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_valid_i) begin
            state_d = READ;
          end
        end
      end
      // tag compare of the request accepted last cycle
      READ: begin
        if (hit) begin
          fetch_rsp_valid_o = 1'b1;
          fetch_ready_o     = ~flush_d;
          state_d           = (fetch_valid_i && !flush_d) ? READ : IDLE;
        end else begin
          // disabled cache reuses the miss path without counting
          mem_req_o = 1'b1;
          miss_o    = cache_en;
          nc_d      = ~cache_en;
          state_d   = MISS;
        end
      end
      // refill is answered in the cycle it arrives
      MISS: begin
        if (mem_rtrn_valid_i) begin
          fetch_rsp_valid_o = 1'b1;
          fill_o            = ~nc_q;
          state_d           = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      nc_q        <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      nc_q        <= nc_d;
    end
  end

  // held request address
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      addr_q <= fetch_req_i.addr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
// types shared by the instruction cache modules, imported where a module needs them
`default_nettype none
`include "icache_params.svh"

package icache_pkg;

  // address fields
  typedef logic [`ICACHE_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_WIDTH-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

  // payload widths
  typedef logic [`ICACHE_WORD_WIDTH-1:0] word_t;
  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

  // way number and one bit per way
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]         way_vec_t;

  // fetch port, lower two address bits are don't care
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    word_t data;
  } fetch_rsp_t;

  // refill request, line aligned unless nc is set
  typedef struct packed {
    addr_t    paddr;
    way_idx_t way;
    logic     nc;
  } mem_req_t;

  // refill return, always one full line in one beat
  typedef struct packed {
    line_t data;
  } mem_rtrn_t;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/icache_params.svh ====
// geometry constants of the instruction cache, included by the package and every RTL file
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// physical address and fetch word
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_WORD_WIDTH 32

// organisation, 4 ways of 16 sets with 16 byte lines
`define ICACHE_WAYS       4
`define ICACHE_SETS       16
`define ICACHE_LINE_BYTES 16

// replacement shift register
`define ICACHE_LFSR_WIDTH 8

// derived address fields
`define ICACHE_OFFSET_WIDTH ($clog2(`ICACHE_LINE_BYTES))
`define ICACHE_INDEX_WIDTH  ($clog2(`ICACHE_SETS))
`define ICACHE_TAG_WIDTH    (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH)
`define ICACHE_LINE_WIDTH   (`ICACHE_LINE_BYTES * 8)

`endif
